//--- ppu_pkg.sv
/*
 * Shared PPU definitions: register numbers, control, mask, status and
 * render-flag structs, the 14-bit PPU address type and the palette page.
 */
package ppu_pkg;

	// CPU-visible register numbers, selected by the 3-bit register address.
	localparam logic [2:0] REG_PPUCTRL   = 3'd0;	// Control, write only.
	localparam logic [2:0] REG_PPUMASK   = 3'd1;	// Render mask, write only.
	localparam logic [2:0] REG_PPUSTATUS = 3'd2;	// Status flags, read only.
	localparam logic [2:0] REG_OAMADDR   = 3'd3;	// OAM pointer.
	localparam logic [2:0] REG_OAMDATA   = 3'd4;	// OAM data port.
	localparam logic [2:0] REG_PPUSCROLL = 3'd5;	// Scroll, ignored here.
	localparam logic [2:0] REG_PPUADDR   = 3'd6;	// VRAM pointer, two writes.
	localparam logic [2:0] REG_PPUDATA   = 3'd7;	// VRAM data port.

	localparam logic [5:0] PALETTE_PAGE = 6'h3F;	// Upper address bits of palette space.

	typedef logic [13:0] ppu_addr_t;	// PPU bus address.

	typedef struct packed {
		logic       nmi_enable;		// Bit 7, NMI at vblank start.
		logic       master_slave;	// Bit 6, EXT pin direction.
		logic       sprite_size;	// Bit 5, 8x8 or 8x16.
		logic       bg_pt_addr;		// Bit 4, background pattern table.
		logic       spr_pt_addr;	// Bit 3, sprite pattern table.
		logic       vram_addr_inc;	// Bit 2, add 1 or 32 per PPUDATA access.
		logic [1:0] base_nt_addr;	// Bits 1:0, base nametable.
	} ppu_ctrl_t;

	typedef struct packed {
		logic [2:0] color_emph_bgr;	// Bits 7:5, colour emphasis.
		logic       show_spr;		// Bit 4.
		logic       show_bg;		// Bit 3.
		logic       show_spr_left;	// Bit 2, leftmost 8 pixels.
		logic       show_bg_left;	// Bit 1, leftmost 8 pixels.
		logic       grayscale;		// Bit 0.
	} ppu_mask_t;

	// Levels from the renderer.
	typedef struct packed {
		logic spr0_hit;
		logic spr_overflow;
	} ppu_render_flags_t;

	typedef struct packed {
		logic       vblank;		// Bit 7, cleared by a status read.
		logic       spr0_hit;		// Bit 6.
		logic       spr_overflow;	// Bit 5.
		logic [4:0] last_write_lsb;	// Bits 4:0, stale bus bits.
	} ppu_status_t;

endpackage

//--- ppu_reg.sv
/*
 * CPU register interface of the PPU: chip-select edge detect, register decode,
 * VRAM and OAM pointers, status flags and the memory write strobes.
 */
`timescale 1ns/1ps

module ppu_reg
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         cs_n,		// Chip select, active low.
	input  logic                         we,		// Level, 1 for a write access.
	input  logic [2:0]                   reg_addr,		// Register number.
	input  logic [7:0]                   cpu_wdata,
	output logic [7:0]                   cpu_rdata,
	input  logic                         vblank_start,	// One-cycle pulse.
	input  ppu_pkg::ppu_render_flags_t   render_flags,
	output ppu_pkg::ppu_ctrl_t           ctrl,
	output ppu_pkg::ppu_mask_t           mask,
	output ppu_pkg::ppu_addr_t           nt_addr,
	output logic [7:0]                   nt_wdata,
	output logic                         nt_we,
	input  logic [7:0]                   nt_rdata,
	output logic [7:0]                   oam_addr,
	output logic [7:0]                   oam_wdata,
	output logic                         oam_we,
	input  logic [7:0]                   oam_rdata,
	output logic [4:0]                   pal_addr,
	output logic [7:0]                   pal_wdata,
	output logic                         pal_we,
	input  logic [7:0]                   pal_rdata
);

	logic                  cs_n_q;		// Chip select one edge ago.
	logic                  access;		// Accepting edge of an access.
	logic                  pal_sel;		// Pointer is in the palette page.
	logic                  inc_pend;	// PPUDATA pointer step due next edge.
	logic                  oam_inc_pend;	// OAM pointer step due next edge.
	logic                  stat_clr_pend;	// Status read side effects due.
	logic                  vblank;
	logic                  toggle;		// 0 = high byte next, 1 = low byte.
	logic [4:0]            last_write_lsb;
	ppu_pkg::ppu_addr_t    vaddr;		// PPUADDR/PPUDATA pointer.
	ppu_pkg::ppu_status_t  status;

	assign access  = ~cs_n & cs_n_q;	// Falling edge of cs_n.
	assign pal_sel = (vaddr[13:8] == ppu_pkg::PALETTE_PAGE);
	assign nt_addr  = vaddr;
	assign pal_addr = vaddr[4:0];	// Palette RAM handles the aliasing.

	always_comb
	begin
		status.vblank         = vblank;
		status.spr0_hit       = render_flags.spr0_hit;	// Sampled at the read.
		status.spr_overflow   = render_flags.spr_overflow;
		status.last_write_lsb = last_write_lsb;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cs_n_q         <= 1'b1;	// Idle bus.
			cpu_rdata      <= '0;
			ctrl           <= '0;
			mask           <= '0;
			vaddr          <= '0;
			toggle         <= 1'b0;
			vblank         <= 1'b0;
			last_write_lsb <= '0;
			inc_pend       <= 1'b0;
			oam_inc_pend   <= 1'b0;
			stat_clr_pend  <= 1'b0;
			oam_addr       <= '0;
			oam_wdata      <= '0;
			oam_we         <= 1'b0;
			nt_wdata       <= '0;
			nt_we          <= 1'b0;
			pal_wdata      <= '0;
			pal_we         <= 1'b0;
		end
		else
		begin
			cs_n_q <= cs_n;

			// Strobes and pending steps last one cycle.
			nt_we         <= 1'b0;
			oam_we        <= 1'b0;
			pal_we        <= 1'b0;
			inc_pend      <= 1'b0;
			oam_inc_pend  <= 1'b0;
			stat_clr_pend <= 1'b0;

			// Edge A+1 of a PPUDATA access, after the write has landed.
			if (inc_pend)
				vaddr <= vaddr + (ctrl.vram_addr_inc ? 14'd32 : 14'd1);
			if (oam_inc_pend)
				oam_addr <= oam_addr + 8'd1;
			if (stat_clr_pend)
			begin
				vblank <= 1'b0;
				toggle <= 1'b0;	// Next PPUADDR write is the high byte.
			end
			if (vblank_start)
				vblank <= 1'b1;	// A new frame wins over the clear.

			if (access)
			begin
				if (we)
					last_write_lsb <= cpu_wdata[4:0];	// Any register.
				case (reg_addr)
					ppu_pkg::REG_PPUCTRL:
						if (we)
							ctrl <= ppu_pkg::ppu_ctrl_t'(cpu_wdata);
					ppu_pkg::REG_PPUMASK:
						if (we)
							mask <= ppu_pkg::ppu_mask_t'(cpu_wdata);
					ppu_pkg::REG_PPUSTATUS:
						if (!we)
						begin
							cpu_rdata     <= status;
							stat_clr_pend <= 1'b1;
						end
					ppu_pkg::REG_OAMADDR:
						if (we)
							oam_addr <= cpu_wdata;
					ppu_pkg::REG_OAMDATA:
						if (we)
						begin
							oam_wdata    <= cpu_wdata;
							oam_we       <= 1'b1;	// Lands at A+1, old address.
							oam_inc_pend <= 1'b1;
						end
						else
							cpu_rdata <= oam_rdata;	// No pointer step on reads.
					ppu_pkg::REG_PPUSCROLL: ;	// Taken, no scroll state kept.
					ppu_pkg::REG_PPUADDR:
						if (we)
						begin
							if (toggle)
								vaddr[7:0] <= cpu_wdata;
							else
								vaddr[13:8] <= cpu_wdata[5:0];	// 14-bit space.
							toggle <= ~toggle;
						end
					ppu_pkg::REG_PPUDATA:
					begin
						if (we)
						begin
							if (pal_sel)
							begin
								pal_wdata <= cpu_wdata;
								pal_we    <= 1'b1;
							end
							else
							begin
								nt_wdata <= cpu_wdata;
								nt_we    <= 1'b1;
							end
						end
						else
							cpu_rdata <= pal_sel ? pal_rdata : nt_rdata;	// Unbuffered.
						inc_pend <= 1'b1;	// Step on reads and writes.
					end
				endcase
			end
		end
	end

endmodule

//--- ppu_nametable_ram.sv
/*
 * 2 KB nametable RAM, folding the PPU address space onto two physical pages
 * with vertical or horizontal mirroring.
 */
`timescale 1ns/1ps

module ppu_nametable_ram
#(
	parameter bit NT_VERTICAL_MIRROR = 1'b1	// 1 = vertical, 0 = horizontal.
)
(
	input  logic               clk,
	input  ppu_pkg::ppu_addr_t addr,
	input  logic [7:0]         wdata,
	input  logic               we,
	output logic [7:0]         rdata
);

	logic [7:0]  mem [0:2047];
	logic        page;		// Physical page select.
	logic [10:0] phys_addr;

	// Vertical mirroring pairs $2000/$2800, horizontal pairs $2000/$2400.
	assign page      = NT_VERTICAL_MIRROR ? addr[10] : addr[11];
	assign phys_addr = {page, addr[9:0]};

	always_ff @(posedge clk)
	begin
		if (we)
			mem[phys_addr] <= wdata;
	end

	assign rdata = mem[phys_addr];	// Combinational read.

endmodule

//--- ppu_oam.sv
/*
 * 256-byte sprite attribute memory.
 */
`timescale 1ns/1ps

module ppu_oam
(
	input  logic       clk,
	input  logic [7:0] addr,
	input  logic [7:0] wdata,
	input  logic       we,
	output logic [7:0] rdata
);

	logic [7:0] mem [0:255];	// 64 sprites, 4 bytes each.

	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
	end

	assign rdata = mem[addr];	// Combinational read.

endmodule

//--- ppu_palette_ram.sv
/*
 * 32-entry palette RAM, 6 bits per colour, with the sprite backdrop entries
 * aliased onto the background backdrop entries.
 */
`timescale 1ns/1ps

module ppu_palette_ram
(
	input  logic       clk,
	input  logic [4:0] addr,
	input  logic [7:0] wdata,
	input  logic       we,
	output logic [7:0] rdata
);

	logic [5:0] mem [0:31];
	logic [4:0] idx;	// Entry after aliasing.

	// $10/$14/$18/$1C share storage with $00/$04/$08/$0C.
	always_comb
	begin
		idx = addr;
		if (addr[4] && (addr[1:0] == 2'b00))
			idx[4] = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (we)
			mem[idx] <= wdata[5:0];	// Only 64 colours exist.
	end

	assign rdata = {2'b00, mem[idx]};

endmodule

//--- ppu_regs_top.sv
/*
 * PPU register block top level: register interface plus nametable, OAM and palette.
 */
`timescale 1ns/1ps

module ppu_regs_top
#(
	parameter bit NT_VERTICAL_MIRROR = 1'b1
)
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       cs_n,
	input  logic                       we,
	input  logic [2:0]                 reg_addr,
	input  logic [7:0]                 cpu_wdata,
	output logic [7:0]                 cpu_rdata,
	input  logic                       vblank_start,
	input  ppu_pkg::ppu_render_flags_t render_flags,
	output ppu_pkg::ppu_ctrl_t         ctrl,
	output ppu_pkg::ppu_mask_t         mask
);

	ppu_pkg::ppu_addr_t nt_addr;
	logic [7:0]         nt_wdata, nt_rdata;
	logic               nt_we;
	logic [7:0]         oam_addr, oam_wdata, oam_rdata;
	logic               oam_we;
	logic [4:0]         pal_addr;
	logic [7:0]         pal_wdata, pal_rdata;
	logic               pal_we;

	ppu_reg u_ppu_reg (
		.clk, .reset, .cs_n, .we, .reg_addr, .cpu_wdata, .cpu_rdata,
		.vblank_start, .render_flags, .ctrl, .mask,
		.nt_addr, .nt_wdata, .nt_we, .nt_rdata,
		.oam_addr, .oam_wdata, .oam_we, .oam_rdata,
		.pal_addr, .pal_wdata, .pal_we, .pal_rdata
	);

	ppu_nametable_ram #(.NT_VERTICAL_MIRROR(NT_VERTICAL_MIRROR)) u_nametable (
		.clk, .addr(nt_addr), .wdata(nt_wdata), .we(nt_we), .rdata(nt_rdata)
	);

	ppu_oam u_oam (
		.clk, .addr(oam_addr), .wdata(oam_wdata), .we(oam_we), .rdata(oam_rdata)
	);

	ppu_palette_ram u_palette (
		.clk, .addr(pal_addr), .wdata(pal_wdata), .we(pal_we), .rdata(pal_rdata)
	);

endmodule

//--- tb_ppu_regs.sv
/*
 * Testbench for the PPU register block: clock and reset, LFSR stimulus,
 * reference model of registers and memories, checks and a cycle timeout.
 */
`timescale 1ns/1ps

module tb_ppu_regs;

	localparam int MAX_CYCLES = 5000;	// About 900 accesses of 4 cycles, plus margin.

	logic                       clk;
	logic                       reset;
	logic                       cs_n;
	logic                       we;
	logic [2:0]                 reg_addr;
	logic [7:0]                 cpu_wdata;
	logic [7:0]                 cpu_rdata;
	logic                       vblank_start;
	ppu_pkg::ppu_render_flags_t render_flags;
	ppu_pkg::ppu_ctrl_t         ctrl;
	ppu_pkg::ppu_mask_t         mask;

	logic [31:0] lfsr;		// Random source state.
	int          cycle_count = 0;

	// Reference model state.
	logic [7:0]  ref_ctrl;
	logic [7:0]  ref_mask;
	logic [4:0]  ref_lsb;		// Low bits of the last write.
	logic        ref_vblank;
	logic        ref_toggle;	// 0 = high byte next.
	logic [13:0] ref_vaddr;
	logic [7:0]  ref_oam_addr;
	logic [7:0]  ref_nt [0:2047];
	logic [7:0]  ref_oam [0:255];
	logic [5:0]  ref_pal [0:31];
	bit          nt_valid [0:2047];	// Location written at least once.
	bit          oam_valid [0:255];
	bit          pal_valid [0:31];

	ppu_regs_top #(.NT_VERTICAL_MIRROR(1'b1)) u_ppu_regs_top (
		.clk, .reset, .cs_n, .we, .reg_addr, .cpu_wdata, .cpu_rdata,
		.vblank_start, .render_flags, .ctrl, .mask
	);

	always #2 clk = ~clk;	// 4 ns period.

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          k;
		val = '0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// Vertical mirroring: bit 10 picks the page, low 10 bits kept.
	function automatic logic [10:0] nt_index(input logic [13:0] addr);
		return {addr[10], addr[9:0]};
	endfunction

	// Sprite backdrops $10/$14/$18/$1C fold onto $00/$04/$08/$0C.
	function automatic logic [4:0] pal_index(input logic [4:0] addr);
		return (addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr;
	endfunction

	task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#0.5;	// Drive just after the edge.
	endtask

	// One bus access: cs_n low for 2 cycles, high for 2. Edge A is the first edge.
	task automatic bus_cycle(input logic wr, input logic [2:0] addr, input logic [7:0] data);
		cs_n      = 1'b0;
		we        = wr;
		reg_addr  = addr;
		cpu_wdata = data;
		repeat (2) next_cycle();
		cs_n = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic pulse_vblank();
		vblank_start = 1'b1;
		next_cycle();
		vblank_start = 1'b0;
		ref_vblank   = 1'b1;
	endtask

	// Runs an access on the DUT and in the model, then checks read data and outputs.
	task automatic reg_access(input string name, input logic wr, input logic [2:0] addr,
		input logic [7:0] data);
		logic [7:0]  expected;
		logic        known;		// Read value is defined by the model.
		logic [10:0] nidx;
		logic [4:0]  pidx;
		logic        in_pal;
		expected = 8'h00;
		known    = 1'b0;
		nidx     = nt_index(ref_vaddr);
		pidx     = pal_index(ref_vaddr[4:0]);
		in_pal   = (ref_vaddr[13:8] == ppu_pkg::PALETTE_PAGE);
		bus_cycle(wr, addr, data);
		if (wr)
			ref_lsb = data[4:0];
		case (addr)
			ppu_pkg::REG_PPUCTRL:
				if (wr)
					ref_ctrl = data;
			ppu_pkg::REG_PPUMASK:
				if (wr)
					ref_mask = data;
			ppu_pkg::REG_PPUSTATUS:
				if (!wr)
				begin
					expected   = {ref_vblank, render_flags.spr0_hit,
						render_flags.spr_overflow, ref_lsb};
					known      = 1'b1;
					ref_vblank = 1'b0;	// Cleared by the read.
					ref_toggle = 1'b0;
				end
			ppu_pkg::REG_OAMADDR:
				if (wr)
					ref_oam_addr = data;
			ppu_pkg::REG_OAMDATA:
				if (wr)
				begin
					ref_oam[ref_oam_addr]   = data;
					oam_valid[ref_oam_addr] = 1'b1;
					ref_oam_addr            = ref_oam_addr + 8'd1;
				end
				else
				begin
					expected = ref_oam[ref_oam_addr];	// Address stays.
					known    = oam_valid[ref_oam_addr];
				end
			ppu_pkg::REG_PPUADDR:
				if (wr)
				begin
					if (ref_toggle)
						ref_vaddr[7:0] = data;
					else
						ref_vaddr[13:8] = data[5:0];
					ref_toggle = ~ref_toggle;
				end
			ppu_pkg::REG_PPUDATA:
			begin
				if (wr && in_pal)
				begin
					ref_pal[pidx]   = data[5:0];
					pal_valid[pidx] = 1'b1;
				end
				else if (wr)
				begin
					ref_nt[nidx]   = data;
					nt_valid[nidx] = 1'b1;
				end
				else if (in_pal)
				begin
					expected = {2'b00, ref_pal[pidx]};	// 6 stored bits.
					known    = pal_valid[pidx];
				end
				else
				begin
					expected = ref_nt[nidx];
					known    = nt_valid[nidx];
				end
				ref_vaddr = ref_vaddr + (ref_ctrl[2] ? 14'd32 : 14'd1);
			end
			default: ;	// PPUSCROLL has no state.
		endcase
		if (known)
			check(name, expected, cpu_rdata);
		check({name, ": ctrl"}, ref_ctrl, ctrl);
		check({name, ": mask"}, ref_mask, mask);
	endtask

	task automatic set_vaddr(input string name, input logic [13:0] addr);
		reg_access(name, 1'b1, ppu_pkg::REG_PPUADDR, {2'b00, addr[13:8]});
		reg_access(name, 1'b1, ppu_pkg::REG_PPUADDR, addr[7:0]);
	endtask

	initial
	begin
		int         i;
		logic [7:0] d;
		logic [7:0] base;
		logic [7:0] first_nt;	// Byte stored at $2000.
		logic [2:0] sel;
		logic [2:0] ra;
		logic       wr_bit;
		clk          = 1'b0;
		reset        = 1'b1;
		cs_n         = 1'b1;
		we           = 1'b0;
		reg_addr     = 3'd0;
		cpu_wdata    = 8'h00;
		vblank_start = 1'b0;
		render_flags = 2'b00;
		lfsr         = 32'h1780;
		ref_ctrl     = 8'h00;
		ref_mask     = 8'h00;
		ref_lsb      = 5'd0;
		ref_vblank   = 1'b0;
		ref_toggle   = 1'b0;
		ref_vaddr    = 14'h0000;
		ref_oam_addr = 8'h00;
		repeat (10) @(posedge clk);
		#0.5;
		reset = 1'b0;
		next_cycle();

		// Reset values, then ctrl and mask writes.
		check("ctrl after reset", 8'h00, ctrl);
		check("mask after reset", 8'h00, mask);
		reg_access("status after reset", 1'b0, ppu_pkg::REG_PPUSTATUS, 8'h00);
		for (i = 0; i < 8; i++)
		begin
			reg_access("ctrl write", 1'b1, ppu_pkg::REG_PPUCTRL, 8'(rand_bits(8)));
			reg_access("mask write", 1'b1, ppu_pkg::REG_PPUMASK, 8'(rand_bits(8)));
		end

		// Status flags, last write bits and vblank clear on read.
		render_flags = 2'b10;	// Sprite-0 hit only.
		reg_access("status lsb write", 1'b1, ppu_pkg::REG_PPUSCROLL, 8'h15);
		pulse_vblank();
		reg_access("status vblank set", 1'b0, ppu_pkg::REG_PPUSTATUS, 8'h00);
		check("status vblank set", 8'h80, cpu_rdata & 8'h80);
		reg_access("status vblank cleared", 1'b0, ppu_pkg::REG_PPUSTATUS, 8'h00);
		check("status vblank cleared", 8'h00, cpu_rdata & 8'h80);

		// OAM writes at consecutive addresses, reads without a pointer step.
		base = 8'(rand_bits(8));
		reg_access("oam address", 1'b1, ppu_pkg::REG_OAMADDR, base);
		for (i = 0; i < 16; i++)
			reg_access("oam write", 1'b1, ppu_pkg::REG_OAMDATA, 8'(rand_bits(8)));
		for (i = 0; i < 16; i++)
		begin
			reg_access("oam address", 1'b1, ppu_pkg::REG_OAMADDR, base + 8'(i));
			reg_access("oam read", 1'b0, ppu_pkg::REG_OAMDATA, 8'h00);
			reg_access("oam read again", 1'b0, ppu_pkg::REG_OAMDATA, 8'h00);
		end

		// PPUDATA with increment 1, then 32.
		reg_access("vram inc 1", 1'b1, ppu_pkg::REG_PPUCTRL, 8'h00);
		set_vaddr("vram inc 1", 14'h2000);
		first_nt = 8'(rand_bits(8));
		reg_access("vram write", 1'b1, ppu_pkg::REG_PPUDATA, first_nt);
		for (i = 1; i < 16; i++)
			reg_access("vram write", 1'b1, ppu_pkg::REG_PPUDATA, 8'(rand_bits(8)));
		set_vaddr("vram inc 1", 14'h2000);
		for (i = 0; i < 16; i++)
			reg_access("vram read inc 1", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);
		reg_access("vram inc 32", 1'b1, ppu_pkg::REG_PPUCTRL, 8'h04);
		set_vaddr("vram inc 32", 14'h2C10);
		for (i = 0; i < 16; i++)
			reg_access("vram write", 1'b1, ppu_pkg::REG_PPUDATA, 8'(rand_bits(8)));
		set_vaddr("vram inc 32", 14'h2410);	// Same page as $2C10.
		for (i = 0; i < 16; i++)
			reg_access("vram read inc 32", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);
		reg_access("vram inc 1", 1'b1, ppu_pkg::REG_PPUCTRL, 8'h00);
		set_vaddr("mirror", 14'h2800);
		reg_access("mirror read", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);
		check("mirror 2800 to 2000", first_nt, cpu_rdata);
		reg_access("toggle", 1'b1, ppu_pkg::REG_PPUADDR, 8'h23);	// High byte only.
		reg_access("toggle reset", 1'b0, ppu_pkg::REG_PPUSTATUS, 8'h00);
		set_vaddr("toggle", 14'h2005);
		reg_access("toggle read", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);

		// Palette fill, 6-bit readback and backdrop alias.
		set_vaddr("palette", 14'h3F00);
		for (i = 0; i < 32; i++)
			reg_access("palette write", 1'b1, ppu_pkg::REG_PPUDATA, 8'(rand_bits(8)));
		set_vaddr("palette", 14'h3F00);
		for (i = 0; i < 32; i++)
			reg_access("palette read", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);
		d = 8'(rand_bits(8));
		set_vaddr("palette alias", 14'h3F10);
		reg_access("palette alias write", 1'b1, ppu_pkg::REG_PPUDATA, d);
		set_vaddr("palette alias", 14'h3F00);
		reg_access("palette alias read", 1'b0, ppu_pkg::REG_PPUDATA, 8'h00);
		check("palette 3F10 at 3F00", {2'b00, d[5:0]}, cpu_rdata);

		// Random mix of all registers, flags and vblank pulses.
		for (i = 0; i < 650; i++)
		begin
			render_flags = 2'(rand_bits(2));
			if (4'(rand_bits(4)) == 4'd0)
				pulse_vblank();
			ra     = 3'(rand_bits(3));
			wr_bit = 1'(rand_bits(1));
			sel    = 3'(rand_bits(3));
			case (ra)
				ppu_pkg::REG_PPUADDR:	// Stay near written nametable and palette space.
					if (ref_toggle)
						d = {3'b000, 5'(rand_bits(5))};
					else if (sel[2:1] == 2'b11)
						d = {2'b00, ppu_pkg::PALETTE_PAGE};
					else
						d = {4'h2, sel[1:0], 2'b00};
				ppu_pkg::REG_OAMADDR:
					d = {3'b000, 5'(rand_bits(5))};
				default:
					d = 8'(rand_bits(8));
			endcase
			reg_access("random mix", wr_bit, ra, d);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- vlog.f
ppu_pkg.sv
ppu_reg.sv
ppu_nametable_ram.sv
ppu_oam.sv
ppu_palette_ram.sv
ppu_regs_top.sv
tb_ppu_regs.sv

//--- run.sh
#!/bin/sh
# Build and run the PPU register block testbench with Verilator.
set -e
rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_ppu_regs -o tb_ppu_regs
./obj_dir/tb_ppu_regs > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation PASSED" sim.log; then
	echo "Run passed"
else
	echo "Run failed"
	exit 1
fi
